// ==== Bender.yml ====
package:
  name: node_graph_frontend

sources:
  - source/graph_pkg.sv
  - source/node_lut_dpram.sv
  - source/node_id_mapper.sv
  - source/edge_list_buffer.sv
  - source/node_graph_frontend.sv
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/node_graph_monitor.sv
      - sim/node_graph_chk.sv
      - sim/node_graph_tb.sv

// ==== flist.f ====
source/graph_pkg.sv
source/node_lut_dpram.sv
source/node_id_mapper.sv
source/edge_list_buffer.sv
source/node_graph_frontend.sv
sim/tb_clock_gen.sv
sim/node_graph_monitor.sv
sim/node_graph_chk.sv
sim/node_graph_tb.sv

// ==== sim/node_graph_chk.sv ====
`timescale 1ns/10ps

module node_graph_chk (
    input logic clk,
    input logic arst_n,
    input logic req_valid,
    input logic ready,
    input logic res_valid,
    input logic assign_wr
);

    int assert_errs = 0;

    // fixed two-cycle lookup latency in both directions
    a_res_after_req: assert property (@(posedge clk) disable iff (!arst_n)
        req_valid && ready |-> ##2 res_valid)
    else begin
        $error("res_valid missing two cycles after an accepted request");
        assert_errs++;
    end

    a_req_before_res: assert property (@(posedge clk) disable iff (!arst_n)
        res_valid |-> $past(req_valid && ready, 2))
    else begin
        $error("res_valid without an accepted request two cycles earlier");
        assert_errs++;
    end

    a_ready_sticky: assert property (@(posedge clk) disable iff (!arst_n)
        ready |=> ready)
    else begin
        $error("ready fell outside of reset");
        assert_errs++;
    end

    a_no_early_write: assert property (@(posedge clk) disable iff (!arst_n)
        !ready |-> !assign_wr)
    else begin
        $error("index written to the table before ready");
        assert_errs++;
    end

endmodule

bind node_id_mapper node_graph_chk u_chk (
    .clk       (clk),
    .arst_n    (arst_n),
    .req_valid (req_valid),
    .ready     (ready),
    .res_valid (res_valid),
    .assign_wr (assign_wr)
);

// ==== sim/node_graph_monitor.sv ====
`timescale 1ns/10ps

module node_graph_monitor
    import graph_pkg::*;
(
    input logic        clk,
    input logic        res_valid,
    input idx_result_t res,
    input node_count_t node_count,
    input logic        overflow
);

    typedef struct packed {
        idx_result_t res;
        node_count_t count;
        logic        overflow;
    } exp_result_t;

    exp_result_t exp_q [$];
    int value_errs    = 0;
    int extra_results = 0;

    task automatic push_expect(
        input logic        is_edge,
        input logic        is_new,
        input node_idx_t   index,
        input node_count_t count,
        input logic        ovf
    );
        exp_q.push_back('{res: '{is_edge, is_new, index}, count: count, overflow: ovf});
    endtask

    function automatic int pending();
        return exp_q.size();
    endfunction

    task automatic check_value(input string sig, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %0h expected %0h", $time, sig, got, exp);
            value_errs++;
        end
    endtask

    // results come back in request order, so the oldest entry matches
    always @(posedge clk) begin
        exp_result_t e;
        if (res_valid) begin
            if (exp_q.size() == 0) begin
                $display("result at %0t arrived with no request outstanding", $time);
                extra_results++;
            end else begin
                e = exp_q.pop_front();
                check_value("res.is_edge", 32'(res.is_edge), 32'(e.res.is_edge));
                check_value("res.is_new", 32'(res.is_new), 32'(e.res.is_new));
                check_value("res.index", 32'(res.index), 32'(e.res.index));
                check_value("node_count", 32'(node_count), 32'(e.count));
                check_value("overflow", 32'(overflow), 32'(e.overflow));
            end
        end
    end

endmodule

// ==== sim/node_graph_tb.sv ====
`timescale 1ns/10ps

module node_graph_tb
    import graph_pkg::*;
();

    typedef struct packed {
        logic       is_edge;
        logic [7:0] c0;
        logic [7:0] c1;
        logic [7:0] c2;
        node_idx_t  exp_idx;
    } stim_t;

    localparam int N_STIM   = 18;
    localparam int N_RANDOM = 1100;
    localparam int WAIT_MAX = 16;

    // repeats back to back, two apart, and across the two table ports
    stim_t stim_tab [N_STIM] = '{
        '{1'b0, "y", "o", "u", 10'd0},
        '{1'b1, "a", "a", "a", 10'd1},
        '{1'b1, "a", "a", "a", 10'd1},
        '{1'b1, "b", "b", "b", 10'd2},
        '{1'b0, "a", "a", "a", 10'd1},
        '{1'b1, "c", "c", "c", 10'd3},
        '{1'b1, "b", "b", "b", 10'd2},
        '{1'b0, "c", "c", "c", 10'd3},
        '{1'b1, "o", "u", "t", 10'd4},
        '{1'b1, "o", "u", "t", 10'd4},
        '{1'b0, "d", "d", "d", 10'd5},
        '{1'b0, "d", "d", "d", 10'd5},
        '{1'b1, "y", "o", "u", 10'd0},
        '{1'b1, "e", "e", "e", 10'd6},
        '{1'b0, "e", "e", "e", 10'd6},
        '{1'b1, "z", "z", "z", 10'd7},
        '{1'b1, "f", "f", "f", 10'd8},
        '{1'b1, "z", "z", "z", 10'd7}
    };

    logic        clk, arst_n, rst_req;
    logic        req_valid, done_in, ready, res_valid, overflow;
    logic        start_end_valid, list_done;
    name_req_t   req;
    idx_result_t res;
    node_count_t node_count;
    node_idx_t   start_idx, end_idx;
    edge_count_t edge_count, edge_rd_addr;
    edge_rec_t   edge_rd_data;

    stim_t       t;
    edge_rec_t   exp_edges [$];
    node_idx_t   cur_src, exp_start, exp_end;
    node_name_t  rname;
    logic        is_new;
    logic [31:0] lcg_state;
    bit          name_used [LUT_DEPTH];
    int          n_seen, timeouts;

    tb_clock_gen u_clk (.rst_req(rst_req), .clk(clk), .arst_n(arst_n));

    node_graph_frontend dut (.*);

    node_graph_monitor mon (
        .clk        (clk),
        .res_valid  (res_valid),
        .res        (res),
        .node_count (node_count),
        .overflow   (overflow)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // five bits per letter with the first letter lowest
    function automatic node_name_t encode_name(input logic [7:0] c0, c1, c2);
        return {5'(c2 - 8'h61), 5'(c1 - 8'h61), 5'(c0 - 8'h61)};
    endfunction

    task automatic send_req(input logic is_edge, input node_name_t name);
        @(posedge clk);
        req_valid <= 1'b1;
        req       <= '{is_edge: is_edge, name: name};
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (ready !== 1'b1 && n < LUT_DEPTH + WAIT_MAX) begin
            @(posedge clk);
            n++;
        end
        if (ready !== 1'b1) begin
            $display("timeout: clear sweep never finished, ready stayed low");
            timeouts++;
        end
    endtask

    task automatic wait_results();
        int n;
        n = 0;
        while (mon.pending() != 0 && n < WAIT_MAX) begin
            @(posedge clk);
            n++;
        end
        if (mon.pending() != 0) begin
            $display("timeout: %0d results never came back", mon.pending());
            timeouts++;
        end
        @(posedge clk);
    endtask

    task automatic wait_list_done();
        int n;
        n = 0;
        while (list_done !== 1'b1 && n < WAIT_MAX) begin
            @(posedge clk);
            n++;
        end
        if (list_done !== 1'b1) begin
            $display("timeout: list_done never rose after done_in");
            timeouts++;
        end
    endtask

    initial begin
        req_valid    = 1'b0;
        req          = '0;
        done_in      = 1'b0;
        edge_rd_addr = '0;
        rst_req      = 1'b0;
        n_seen       = 0;
        timeouts     = 0;
        lcg_state    = 32'he4e7_0bc5;

        // the first edge under reset has already cleared the state by the second
        repeat (2) @(posedge clk);
        mon.check_value("ready", 32'(ready), 32'd0);
        wait_ready();

        // index is the count of distinct names seen before
        for (int i = 0; i < N_STIM; i++) begin
            t      = stim_tab[i];
            is_new = (t.exp_idx == node_idx_t'(n_seen));
            if (is_new) begin
                n_seen++;
            end
            send_req(t.is_edge, encode_name(t.c0, t.c1, t.c2));
            mon.push_expect(t.is_edge, is_new, t.exp_idx, node_count_t'(n_seen), 1'b0);
            if (!t.is_edge) begin
                cur_src = t.exp_idx;
            end else begin
                exp_edges.push_back('{src: cur_src, dst: t.exp_idx});
            end
            if (!t.is_edge && {t.c0, t.c1, t.c2} == "you") begin
                exp_start = t.exp_idx;
            end
            if (t.is_edge && {t.c0, t.c1, t.c2} == "out") begin
                exp_end = t.exp_idx;
            end
        end
        @(posedge clk);
        req_valid <= 1'b0;
        wait_results();
        mon.check_value("start_idx", 32'(start_idx), 32'(exp_start));
        mon.check_value("end_idx", 32'(end_idx), 32'(exp_end));
        mon.check_value("start_end_valid", 32'(start_end_valid), 32'd1);

        @(posedge clk);
        done_in <= 1'b1;
        @(posedge clk);
        done_in <= 1'b0;
        wait_list_done();
        mon.check_value("edge_count", 32'(edge_count), 32'(exp_edges.size()));
        // read data lands one cycle after the address
        for (int a = 0; a < exp_edges.size(); a++) begin
            @(posedge clk);
            edge_rd_addr <= edge_count_t'(a);
            @(posedge clk);
            @(posedge clk);
            mon.check_value("edge_rd_data.src", 32'(edge_rd_data.src), 32'(exp_edges[a].src));
            mon.check_value("edge_rd_data.dst", 32'(edge_rd_data.dst), 32'(exp_edges[a].dst));
        end

        // fresh reset and then more distinct names than the index space holds
        @(posedge clk);
        rst_req <= 1'b1;
        @(posedge clk);
        rst_req <= 1'b0;
        mon.check_value("ready", 32'(ready), 32'd0);
        wait_ready();
        for (int i = 0; i < N_RANDOM; i++) begin
            do begin
                lcg_state = lcg_next(lcg_state);
                rname     = node_name_t'(lcg_state[30:16]);
            end while (name_used[rname]);
            name_used[rname] = 1'b1;
            send_req(lcg_state[31], rname);
            if (i < MAX_NODES) begin
                mon.push_expect(lcg_state[31], 1'b1, node_idx_t'(i), node_count_t'(i + 1), 1'b0);
            end else begin
                mon.push_expect(lcg_state[31], 1'b0, '0, node_count_t'(MAX_NODES), 1'b1);
            end
        end
        @(posedge clk);
        req_valid <= 1'b0;
        wait_results();
        mon.check_value("node_count", 32'(node_count), 32'(MAX_NODES));
        mon.check_value("overflow", 32'(overflow), 32'd1);

        $display("value errors: %0d, unmatched results: %0d, assertion errors: %0d, timeouts: %0d",
                 mon.value_errs, mon.extra_results, dut.u_mapper.u_chk.assert_errs, timeouts);
        if (mon.value_errs == 0 && mon.extra_results == 0
                && dut.u_mapper.u_chk.assert_errs == 0 && timeouts == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen (
    input  logic rst_req,
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset at time zero and again on every request
    initial begin
        arst_n = 1'b0;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        forever begin
            @(posedge rst_req);
            arst_n <= 1'b0;
            repeat (2) @(posedge clk);
            arst_n <= 1'b1;
        end
    end

endmodule

// ==== source/edge_list_buffer.sv ====
`timescale 1ns/10ps

module edge_list_buffer
    import graph_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,

    input  logic        res_valid,
    input  idx_result_t res,
    input  logic        done_in,

    output edge_count_t edge_count,
    input  edge_count_t edge_rd_addr,
    output edge_rec_t   edge_rd_data,
    output logic        list_done
);

    localparam int EDGE_AW = $clog2(MAX_EDGES);

    edge_rec_t mem [MAX_EDGES];
    node_idx_t src_idx;
    logic      edge_wr;

    // drop edges once the list is full
    assign edge_wr = res_valid && res.is_edge
                  && (edge_count < edge_count_t'(MAX_EDGES));

    // latest source line
    always_ff @(posedge clk) begin
        if (res_valid && !res.is_edge) begin
            src_idx <= res.index;
        end
    end

    always_ff @(posedge clk) begin
        if (edge_wr) begin
            mem[edge_count[EDGE_AW-1:0]] <= '{src: src_idx, dst: res.index};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            edge_count <= '0;
            list_done  <= 1'b0;
        end else begin
            if (edge_wr) begin
                edge_count <= edge_count + 1'b1;
            end
            // sticky until the next reset
            if (done_in) begin
                list_done <= 1'b1;
            end
        end
    end

    // registered read, addresses past the array return zero
    always_ff @(posedge clk) begin
        if (edge_rd_addr < edge_count_t'(MAX_EDGES)) begin
            edge_rd_data <= mem[edge_rd_addr[EDGE_AW-1:0]];
        end else begin
            edge_rd_data <= '0;
        end
    end

endmodule

// ==== source/graph_pkg.sv ====
package graph_pkg;

    // name and index space
    localparam int NAME_WIDTH = 15;
    localparam int MAX_NODES  = 1024;
    localparam int IDX_WIDTH  = 10;
    localparam int MAX_EDGES  = 2048;
    localparam int LUT_DEPTH  = 2 ** NAME_WIDTH;

    typedef logic [NAME_WIDTH-1:0] node_name_t;
    typedef logic [IDX_WIDTH-1:0]  node_idx_t;
    typedef logic [IDX_WIDTH:0]    node_count_t;
    typedef logic [11:0]           edge_count_t;

    // first letter in the low five bits, each letter counted from 'a'
    function automatic node_name_t pack_name(
        input byte unsigned c0,
        input byte unsigned c1,
        input byte unsigned c2
    );
        node_name_t n;
        n[4:0]   = 5'(c0 - 8'h61);
        n[9:5]   = 5'(c1 - 8'h61);
        n[14:10] = 5'(c2 - 8'h61);
        return n;
    endfunction

    localparam node_name_t START_NAME = pack_name("y", "o", "u");
    localparam node_name_t END_NAME   = pack_name("o", "u", "t");

    typedef struct packed {
        logic       is_edge;
        node_name_t name;
    } name_req_t;

    typedef struct packed {
        logic      is_edge;
        logic      is_new;
        node_idx_t index;
    } idx_result_t;

    typedef struct packed {
        logic      assigned;
        node_idx_t index;
    } lut_entry_t;

    typedef struct packed {
        node_idx_t src;
        node_idx_t dst;
    } edge_rec_t;

endpackage

// ==== source/node_graph_frontend.sv ====
`timescale 1ns/10ps

module node_graph_frontend
    import graph_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,

    // name requests from the parser
    input  logic        req_valid,
    input  name_req_t   req,
    input  logic        done_in,
    output logic        ready,

    // indexed results
    output logic        res_valid,
    output idx_result_t res,
    output node_count_t node_count,
    output logic        overflow,

    output node_idx_t   start_idx,
    output node_idx_t   end_idx,
    output logic        start_end_valid,

    // edge list
    output edge_count_t edge_count,
    input  edge_count_t edge_rd_addr,
    output edge_rec_t   edge_rd_data,
    output logic        list_done
);

    logic done_out;

    node_id_mapper u_mapper (
        .clk             (clk),
        .arst_n          (arst_n),
        .req_valid       (req_valid),
        .req             (req),
        .done_in         (done_in),
        .ready           (ready),
        .res_valid       (res_valid),
        .res             (res),
        .node_count      (node_count),
        .overflow        (overflow),
        .start_idx       (start_idx),
        .end_idx         (end_idx),
        .start_end_valid (start_end_valid),
        .done_out        (done_out)
    );

    edge_list_buffer u_edges (
        .clk          (clk),
        .arst_n       (arst_n),
        .res_valid    (res_valid),
        .res          (res),
        .done_in      (done_out),
        .edge_count   (edge_count),
        .edge_rd_addr (edge_rd_addr),
        .edge_rd_data (edge_rd_data),
        .list_done    (list_done)
    );

endmodule

// ==== source/node_id_mapper.sv ====
`timescale 1ns/10ps

module node_id_mapper
    import graph_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,

    input  logic        req_valid,
    input  name_req_t   req,
    input  logic        done_in,
    output logic        ready,

    output logic        res_valid,
    output idx_result_t res,
    output node_count_t node_count,
    output logic        overflow,

    output node_idx_t   start_idx,
    output node_idx_t   end_idx,
    output logic        start_end_valid,
    output logic        done_out
);

    typedef enum logic {
        ST_CLEAR,
        ST_RUN
    } map_state_t;

    map_state_t state;
    node_name_t clr_addr;

    // table ports
    node_name_t a_name;
    node_name_t b_name;
    logic       a_wr_en;
    logic       b_wr_en;
    lut_entry_t lut_wr_data;
    lut_entry_t a_rd_data;
    lut_entry_t b_rd_data;
    logic       src_in;

    // stage 1
    logic       s1_valid;
    name_req_t  s1_req;
    lut_entry_t s1_entry;

    // index assignment
    logic       new_name;
    logic       full;
    logic       assign_wr;
    node_idx_t  next_idx;

    // write history for forwarding, assigned doubles as valid
    node_name_t fwd0_name;
    node_name_t fwd1_name;
    lut_entry_t fwd0_entry;
    lut_entry_t fwd1_entry;

    node_name_t res_name;
    logic       start_seen;
    logic       end_seen;
    logic       done_d;

    assign ready = (state == ST_RUN);

    // clear sweep over the whole table, then run forever
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= ST_CLEAR;
            clr_addr <= '0;
        end else if (state == ST_CLEAR) begin
            clr_addr <= clr_addr + 1'b1;
            if (clr_addr == node_name_t'(LUT_DEPTH - 1)) begin
                state <= ST_RUN;
            end
        end
    end

    // incoming lookup takes its own port, the pending write takes the other one
    assign src_in = req_valid && !req.is_edge;

    always_comb begin
        if (state == ST_CLEAR) begin
            a_name      = clr_addr;
            b_name      = clr_addr;
            a_wr_en     = 1'b1;
            b_wr_en     = 1'b1;
            lut_wr_data = '0;
        end else begin
            a_name      = src_in ? req.name : s1_req.name;
            b_name      = src_in ? s1_req.name : req.name;
            a_wr_en     = assign_wr && !src_in;
            b_wr_en     = assign_wr && src_in;
            lut_wr_data = '{assigned: 1'b1, index: next_idx};
        end
    end

    node_lut_dpram u_lut (
        .clk       (clk),
        .a_name    (a_name),
        .a_wr_en   (a_wr_en),
        .a_wr_data (lut_wr_data),
        .a_rd_data (a_rd_data),
        .b_name    (b_name),
        .b_wr_en   (b_wr_en),
        .b_wr_data (lut_wr_data),
        .b_rd_data (b_rd_data)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= req_valid && ready;
        end
    end

    always_ff @(posedge clk) begin
        s1_req <= req;
    end

    // read data is stale when the same name was written on the last edges
    always_comb begin
        s1_entry = s1_req.is_edge ? b_rd_data : a_rd_data;
        if (fwd1_entry.assigned && fwd1_name == s1_req.name) begin
            s1_entry = fwd1_entry;
        end
        if (fwd0_entry.assigned && fwd0_name == s1_req.name) begin
            s1_entry = fwd0_entry;
        end
    end

    assign next_idx  = node_idx_t'(node_count);
    assign full      = (node_count == node_count_t'(MAX_NODES));
    assign new_name  = s1_valid && !s1_entry.assigned;
    assign assign_wr = new_name && !full;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fwd0_entry <= '0;
            fwd1_entry <= '0;
            res_valid  <= 1'b0;
            node_count <= '0;
            overflow   <= 1'b0;
        end else begin
            fwd0_entry <= assign_wr ? lut_wr_data : '0;
            fwd1_entry <= fwd0_entry;
            res_valid  <= s1_valid;
            if (assign_wr) begin
                node_count <= node_count + 1'b1;
            end
            if (new_name && full) begin
                overflow <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        fwd0_name   <= s1_req.name;
        fwd1_name   <= fwd0_name;
        res_name    <= s1_req.name;
        res.is_edge <= s1_req.is_edge;
        res.is_new  <= assign_wr;
        if (s1_entry.assigned) begin
            res.index <= s1_entry.index;
        end else if (full) begin
            res.index <= '0;
        end else begin
            res.index <= next_idx;
        end
    end

    // start is a source line, end only shows up as a destination
    always_ff @(posedge clk) begin
        if (res_valid && !res.is_edge && res_name == START_NAME) begin
            start_idx <= res.index;
        end
        if (res_valid && res.is_edge && res_name == END_NAME) begin
            end_idx <= res.index;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            start_seen      <= 1'b0;
            end_seen        <= 1'b0;
            start_end_valid <= 1'b0;
            done_d          <= 1'b0;
            done_out        <= 1'b0;
        end else begin
            if (res_valid && !res.is_edge && res_name == START_NAME) begin
                start_seen <= 1'b1;
            end
            if (res_valid && res.is_edge && res_name == END_NAME) begin
                end_seen <= 1'b1;
            end
            start_end_valid <= start_seen && end_seen;
            // same two-cycle delay as the lookup
            done_d   <= done_in;
            done_out <= done_d;
        end
    end

endmodule

// ==== source/node_lut_dpram.sv ====
`timescale 1ns/10ps

module node_lut_dpram
    import graph_pkg::*;
(
    input  logic       clk,

    // port a
    input  node_name_t a_name,
    input  logic       a_wr_en,
    input  lut_entry_t a_wr_data,
    output lut_entry_t a_rd_data,

    // port b
    input  node_name_t b_name,
    input  logic       b_wr_en,
    input  lut_entry_t b_wr_data,
    output lut_entry_t b_rd_data
);

    // one entry per possible packed name
    lut_entry_t mem [LUT_DEPTH];

    // read-first on both ports, port b wins on a same-address write
    always_ff @(posedge clk) begin
        if (a_wr_en) begin
            mem[a_name] <= a_wr_data;
        end
        if (b_wr_en) begin
            mem[b_name] <= b_wr_data;
        end
        a_rd_data <= mem[a_name];
        b_rd_data <= mem[b_name];
    end

endmodule
